/* include/fetch_defs.svh */
// Sizing constants for the fetch front end.
// Include in any file that needs the reset pc or a table or queue size.

`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// pc loaded when reset is released.
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// prediction counters, indexed by pc bits 5..2.
`define BHT_ENTRIES 16

// fetch queue entries and the credits decode grants at reset.
`define FQ_DEPTH 4
`define DECODE_CREDITS 2

// instruction memory size in 32-bit words.
`define IMEM_WORDS 256

`endif

/* design/fetch_pkg.sv */
// Shared types for the fetch front end.
// Modules import this package inside their bodies and use scoped names on ports.

package fetch_pkg;

    typedef logic [63:0] pc_t;
    typedef logic [63:0] xlen_t;
    typedef logic [31:0] inst_t;

    // four instructions, slot 0 in the low bits.
    typedef logic [127:0] line_t;

    // number of valid slots in a packet, 1 to 4.
    typedef logic [2:0] slot_cnt_t;

    typedef logic [3:0] bht_idx_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [1:0] credit_t;

    // major opcodes that matter to fetch.
    typedef enum logic [1:0] {
        OP_OTHER  = 2'd0,
        OP_JAL    = 2'd1,
        OP_JALR   = 2'd2,
        OP_BRANCH = 2'd3
    } opcode_e;

endpackage

/* design/branch_history.sv */
// Table of 2-bit saturating counters for conditional branch prediction.
// Fetch reads one entry per cycle; the branch unit updates one entry per cycle.

`include "fetch_defs.svh"

module branch_history (
    input  logic                clk,
    input  logic                i_reset,

    // prediction lookup.
    input  fetch_pkg::bht_idx_t i_rd_index,
    output logic                o_rd_taken,

    // resolution from the branch unit.
    input  logic                i_upd_valid,
    input  fetch_pkg::bht_idx_t i_upd_index,
    input  logic                i_upd_taken
);

    logic [1:0] counters [`BHT_ENTRIES];
    logic [1:0] upd_cnt;

    // weakly taken and strongly taken both have the upper bit set.
    assign o_rd_taken = counters[i_rd_index][1];

    assign upd_cnt = counters[i_upd_index];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            // start weakly not taken.
            for (int i = 0; i < `BHT_ENTRIES; i++) begin
                counters[i] <= 2'd1;
            end
        end else if (i_upd_valid) begin
            if (i_upd_taken) begin
                if (upd_cnt != 2'd3) begin
                    counters[i_upd_index] <= upd_cnt + 2'd1;
                end
            end else begin
                if (upd_cnt != 2'd0) begin
                    counters[i_upd_index] <= upd_cnt - 2'd1;
                end
            end
        end
    end

endmodule

/* design/inst_mem.sv */
// Instruction memory for fetch.
// Loaded one word per cycle while reset is held, then read as 16-byte lines
// in the same cycle the pc is presented.

`include "fetch_defs.svh"

module inst_mem (
    input  logic                              clk,

    // load port.
    input  logic                              i_we,
    input  logic [$clog2(`IMEM_WORDS)-1:0]    i_waddr,
    input  fetch_pkg::inst_t                  i_wdata,

    // line read.
    input  fetch_pkg::pc_t                    i_pc,
    output fetch_pkg::line_t                  o_line
);

    import fetch_pkg::*;

    localparam int LINE_BITS = $clog2(`IMEM_WORDS / 4);

    inst_t               mem [`IMEM_WORDS];
    logic [LINE_BITS-1:0] line_idx;

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // pc bits 3..0 select within the line and are dropped here.
    assign line_idx = i_pc[LINE_BITS+3:4];

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            o_line[i*32 +: 32] = mem[{line_idx, 2'(i)}];
        end
    end

endmodule

/* design/fetch_pc.sv */
// Next-pc logic for the four-wide fetch stage.
// Predecodes the current line, picks the first taken control transfer,
// handles redirects from decode and trap, and holds a redirect that
// arrives while the fetch queue is full.

`include "fetch_defs.svh"

module fetch_pc (
    input  logic                 clk,
    input  logic                 i_reset,

    input  fetch_pkg::line_t     i_line,
    input  logic                 i_stall,

    // redirects, highest priority first.
    input  logic                 i_dec1_valid,
    input  fetch_pkg::pc_t       i_dec1_pc,
    input  logic                 i_dec2_valid,
    input  fetch_pkg::pc_t       i_dec2_pc,
    input  logic                 i_trap_valid,
    input  fetch_pkg::pc_t       i_trap_pc,

    // branch prediction lookup.
    output fetch_pkg::bht_idx_t  o_bht_index,
    input  logic                 i_bht_taken,

    // jalr base register read.
    output logic                 o_jreg_en,
    output fetch_pkg::reg_idx_t  o_jreg_addr,
    input  fetch_pkg::xlen_t     i_jreg_data,

    output fetch_pkg::pc_t       o_pc,
    output logic                 o_push,
    output fetch_pkg::slot_cnt_t o_push_count,
    output logic                 o_flush
);

    import fetch_pkg::*;

    pc_t       pc_q;
    pc_t       line_base;
    logic [1:0] offset;

    inst_t     slot_inst [4];
    pc_t       slot_pc   [4];
    opcode_e   slot_op   [4];

    logic      br_found;
    logic [1:0] br_slot;
    logic      tk_found;
    logic [1:0] tk_slot;
    pc_t       target;
    pc_t       seq_pc;

    logic      redir_valid;
    pc_t       redir_pc;
    pc_t       next_pc;

    logic      pend_valid;
    pc_t       pend_pc;

    function automatic opcode_e decode_op(input inst_t inst);
        opcode_e op;
        case (inst[6:0])
            7'b1101111: op = OP_JAL;
            7'b1100111: op = OP_JALR;
            7'b1100011: op = OP_BRANCH;
            default:    op = OP_OTHER;
        endcase
        return op;
    endfunction

    function automatic xlen_t imm_j(input inst_t inst);
        return {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

    function automatic xlen_t imm_b(input inst_t inst);
        return {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    function automatic xlen_t imm_i(input inst_t inst);
        return {{52{inst[31]}}, inst[31:20]};
    endfunction

    assign line_base = {pc_q[63:4], 4'b0000};
    assign offset    = pc_q[3:2];
    assign seq_pc    = line_base + 64'd16;

    // slots below the pc offset are not part of this packet.
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            slot_inst[i] = i_line[i*32 +: 32];
            slot_pc[i]   = line_base + pc_t'(4 * i);
            slot_op[i]   = (2'(i) >= offset) ? decode_op(slot_inst[i]) : OP_OTHER;
        end
    end

    // only the first branch in the line gets a prediction.
    always_comb begin
        br_found = 1'b0;
        br_slot  = 2'd0;
        for (int i = 0; i < 4; i++) begin
            if (!br_found && slot_op[i] == OP_BRANCH) begin
                br_found = 1'b1;
                br_slot  = 2'(i);
            end
        end
    end

    assign o_bht_index = slot_pc[br_slot][5:2];

    always_comb begin
        tk_found = 1'b0;
        tk_slot  = 2'd0;
        for (int i = 0; i < 4; i++) begin
            if (!tk_found && (slot_op[i] == OP_JAL || slot_op[i] == OP_JALR ||
                (slot_op[i] == OP_BRANCH && 2'(i) == br_slot && i_bht_taken))) begin
                tk_found = 1'b1;
                tk_slot  = 2'(i);
            end
        end
    end

    always_comb begin
        case (slot_op[tk_slot])
            OP_JAL:  target = slot_pc[tk_slot] + imm_j(slot_inst[tk_slot]);
            OP_JALR: target = (i_jreg_data + imm_i(slot_inst[tk_slot])) & ~64'd1;
            default: target = slot_pc[tk_slot] + imm_b(slot_inst[tk_slot]);
        endcase
    end

    assign o_jreg_en   = tk_found && (slot_op[tk_slot] == OP_JALR);
    assign o_jreg_addr = slot_inst[tk_slot][19:15];

    // packet ends at the taken slot, inclusive.
    assign o_push_count = tk_found ? slot_cnt_t'(3'(tk_slot) + 3'd1 - 3'(offset))
                                   : slot_cnt_t'(3'd4 - 3'(offset));

    always_comb begin
        redir_valid = i_dec1_valid | i_dec2_valid | i_trap_valid;
        if (i_dec1_valid) begin
            redir_pc = i_dec1_pc;
        end else if (i_dec2_valid) begin
            redir_pc = i_dec2_pc;
        end else begin
            redir_pc = i_trap_pc;
        end
    end

    // a live redirect beats the stored one.
    always_comb begin
        if (redir_valid) begin
            next_pc = redir_pc;
        end else if (pend_valid) begin
            next_pc = pend_pc;
        end else if (tk_found) begin
            next_pc = target;
        end else begin
            next_pc = seq_pc;
        end
    end

    assign o_pc    = pc_q;
    assign o_flush = redir_valid;
    assign o_push  = !i_stall && !redir_valid && !pend_valid;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            pc_q       <= `FETCH_RESET_PC;
            pend_valid <= 1'b0;
        end else if (i_stall) begin
            if (redir_valid) begin
                pend_valid <= 1'b1;
            end
        end else begin
            pc_q       <= next_pc;
            pend_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_stall && redir_valid) begin
            pend_pc <= redir_pc;
        end
    end

endmodule

/* design/fetch_queue.sv */
// Packet queue between fetch and decode.
// Packets leave one per cycle while decode holds credits; decode returns
// a credit per consumed packet. A flush drops everything queued.

`include "fetch_defs.svh"

module fetch_queue (
    input  logic                 clk,
    input  logic                 i_reset,

    input  logic                 i_push,
    input  fetch_pkg::pc_t       i_push_pc,
    input  fetch_pkg::line_t     i_push_line,
    input  fetch_pkg::slot_cnt_t i_push_count,

    input  logic                 i_flush,
    output logic                 o_full,

    input  logic                 i_credit_return,

    output logic                 o_pkt_valid,
    output fetch_pkg::pc_t       o_pkt_pc,
    output fetch_pkg::line_t     o_pkt_line,
    output fetch_pkg::slot_cnt_t o_pkt_count
);

    import fetch_pkg::*;

    localparam int PTR_W = $clog2(`FQ_DEPTH);

    pc_t        q_pc    [`FQ_DEPTH];
    line_t      q_line  [`FQ_DEPTH];
    slot_cnt_t  q_count [`FQ_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   used;
    credit_t          credits;
    logic             do_push;
    logic             do_issue;

    assign o_full   = (used == (PTR_W+1)'(`FQ_DEPTH));
    assign do_push  = i_push && !o_full;
    // nothing older than a redirect reaches decode.
    assign do_issue = (used != '0) && (credits != '0) && !i_flush;

    assign o_pkt_valid = do_issue;
    assign o_pkt_pc    = q_pc[rd_ptr];
    assign o_pkt_line  = q_line[rd_ptr];
    assign o_pkt_count = q_count[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            q_pc[wr_ptr]    <= i_push_pc;
            q_line[wr_ptr]  <= i_push_line;
            q_count[wr_ptr] <= i_push_count;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset || i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_issue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_issue})
                2'b10:   used <= used + 1'b1;
                2'b01:   used <= used - 1'b1;
                default: used <= used;
            endcase
        end
    end

    // credits survive a flush.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            credits <= credit_t'(`DECODE_CREDITS);
        end else begin
            case ({do_issue, i_credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

/* design/fetch_top.sv */
// Fetch front end: pc generation, branch history, instruction memory
// and the packet queue to decode.
// The memory load port is only used while reset is held.

`include "fetch_defs.svh"

module fetch_top (
    input  logic                             clk,
    input  logic                             i_reset,

    input  logic                             i_imem_we,
    input  logic [$clog2(`IMEM_WORDS)-1:0]   i_imem_addr,
    input  fetch_pkg::inst_t                 i_imem_wdata,

    input  logic                             i_dec1_valid,
    input  fetch_pkg::pc_t                   i_dec1_pc,
    input  logic                             i_dec2_valid,
    input  fetch_pkg::pc_t                   i_dec2_pc,
    input  logic                             i_trap_valid,
    input  fetch_pkg::pc_t                   i_trap_pc,

    input  logic                             i_bru_valid,
    input  fetch_pkg::bht_idx_t              i_bru_index,
    input  logic                             i_bru_taken,

    output logic                             o_jreg_en,
    output fetch_pkg::reg_idx_t              o_jreg_addr,
    input  fetch_pkg::xlen_t                 i_jreg_data,

    input  logic                             i_credit_return,

    output logic                             o_pkt_valid,
    output fetch_pkg::pc_t                   o_pkt_pc,
    output fetch_pkg::line_t                 o_pkt_line,
    output fetch_pkg::slot_cnt_t             o_pkt_count
);

    import fetch_pkg::*;

    pc_t       pc;
    line_t     line;
    bht_idx_t  bht_index;
    logic      bht_taken;
    logic      push;
    slot_cnt_t push_count;
    logic      flush;
    logic      full;

    branch_history branch_history_inst (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_rd_index  (bht_index),
        .o_rd_taken  (bht_taken),
        .i_upd_valid (i_bru_valid),
        .i_upd_index (i_bru_index),
        .i_upd_taken (i_bru_taken)
    );

    inst_mem inst_mem_inst (
        .clk     (clk),
        .i_we    (i_imem_we),
        .i_waddr (i_imem_addr),
        .i_wdata (i_imem_wdata),
        .i_pc    (pc),
        .o_line  (line)
    );

    fetch_pc fetch_pc_inst (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_line       (line),
        .i_stall      (full),
        .i_dec1_valid (i_dec1_valid),
        .i_dec1_pc    (i_dec1_pc),
        .i_dec2_valid (i_dec2_valid),
        .i_dec2_pc    (i_dec2_pc),
        .i_trap_valid (i_trap_valid),
        .i_trap_pc    (i_trap_pc),
        .o_bht_index  (bht_index),
        .i_bht_taken  (bht_taken),
        .o_jreg_en    (o_jreg_en),
        .o_jreg_addr  (o_jreg_addr),
        .i_jreg_data  (i_jreg_data),
        .o_pc         (pc),
        .o_push       (push),
        .o_push_count (push_count),
        .o_flush      (flush)
    );

    fetch_queue fetch_queue_inst (
        .clk             (clk),
        .i_reset         (i_reset),
        .i_push          (push),
        .i_push_pc       (pc),
        .i_push_line     (line),
        .i_push_count    (push_count),
        .i_flush         (flush),
        .o_full          (full),
        .i_credit_return (i_credit_return),
        .o_pkt_valid     (o_pkt_valid),
        .o_pkt_pc        (o_pkt_pc),
        .o_pkt_line      (o_pkt_line),
        .o_pkt_count     (o_pkt_count)
    );

endmodule

/* verif/fetch_checker.sv */
// Packet and jalr register port checker for the fetch front end.
// Compares every issued packet with the expectation that the testbench
// drives for the current step, keeps the check and error counts, and counts
// the cycles in which the jalr register port is enabled.

module fetch_checker (
    input  logic         clk,
    input  logic         i_active,
    input  int           i_step,

    input  logic         i_pkt_valid,
    input  logic [63:0]  i_pkt_pc,
    input  logic [127:0] i_pkt_line,
    input  logic [2:0]   i_pkt_count,
    input  logic         i_jreg_en,
    input  logic [4:0]   i_jreg_addr,

    input  logic [63:0]  i_exp_pc,
    input  logic [127:0] i_exp_line,
    input  logic [2:0]   i_exp_count,
    input  logic [4:0]   i_exp_rs1,

    output int           o_checks,
    output int           o_errors,
    output int           o_jreg_hits
);

    timeunit 1ns;
    timeprecision 100ps;

    int bad;

    initial begin
        o_checks = 0;
        o_errors = 0;
        o_jreg_hits = 0;
    end

    // outputs settle by the falling edge.
    always @(negedge clk) begin
        if (i_active && i_pkt_valid) begin
            bad = 0;
            o_checks = o_checks + 1;
            if (i_pkt_pc !== i_exp_pc) begin
                $display("Fail step %0d o_pkt_pc: got %h, expected %h", i_step, i_pkt_pc,
                         i_exp_pc);
                bad = bad + 1;
            end
            if (i_pkt_count !== i_exp_count) begin
                $display("Fail step %0d o_pkt_count: got %h, expected %h", i_step,
                         i_pkt_count, i_exp_count);
                bad = bad + 1;
            end
            if (i_pkt_line !== i_exp_line) begin
                $display("Fail step %0d o_pkt_line: got %h, expected %h", i_step,
                         i_pkt_line, i_exp_line);
                bad = bad + 1;
            end
            if (bad == 0) begin
                $display("step %0d ok: pc %h count %0d", i_step, i_pkt_pc, i_pkt_count);
            end
            o_errors = o_errors + bad;
        end
        if (i_active && i_jreg_en) begin
            o_jreg_hits = o_jreg_hits + 1;
            if (i_jreg_addr !== i_exp_rs1) begin
                $display("Fail step %0d o_jreg_addr: got %h, expected %h", i_step,
                         i_jreg_addr, i_exp_rs1);
                o_errors = o_errors + 1;
            end
        end
    end

endmodule

/* verif/tb_fetch.sv */
// Testbench for the fetch front end.
// Loads a small program, then walks a table of steps, each of which
// ends with exactly one packet issued to decode.

`include "fetch_defs.svh"

module tb_fetch;

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct {
        logic [2:0]  redir;
        logic [63:0] rpc;
        int          bru_pulses;
        logic [3:0]  bru_idx;
        logic [63:0] jreg;
        bit          credit;
        bit          hold;
        logic [63:0] exp_pc;
        logic [2:0]  exp_count;
    } step_t;

    localparam int NUM_STEPS = 19;
    localparam int WAIT_LIMIT = 100;

    logic clk, i_reset, i_imem_we, i_dec1_valid, i_dec2_valid, i_trap_valid;
    logic i_bru_valid, i_bru_taken, i_credit_return, o_jreg_en, o_pkt_valid;
    logic [7:0]   i_imem_addr;
    logic [31:0]  i_imem_wdata;
    logic [63:0]  i_dec1_pc, i_dec2_pc, i_trap_pc, i_jreg_data, o_pkt_pc, exp_pc;
    logic [3:0]   i_bru_index;
    logic [4:0]   o_jreg_addr;
    logic [127:0] o_pkt_line, exp_line;
    logic [2:0]   o_pkt_count, exp_count;
    logic         active;
    int           step_num, checks, chk_errors, tb_errors, jreg_hits;
    bit           timed_out;
    logic [31:0]  prog [`IMEM_WORDS];
    step_t        steps [NUM_STEPS];
    int unsigned  lcg_state;

    fetch_top fetch_top_inst (.*);

    fetch_checker checker_inst (
        .clk(clk), .i_active(active), .i_step(step_num),
        .i_pkt_valid(o_pkt_valid), .i_pkt_pc(o_pkt_pc), .i_pkt_line(o_pkt_line),
        .i_pkt_count(o_pkt_count), .i_jreg_en(o_jreg_en), .i_jreg_addr(o_jreg_addr),
        .i_exp_pc(exp_pc), .i_exp_line(exp_line), .i_exp_count(exp_count),
        .i_exp_rs1(5'd5), .o_checks(checks), .o_errors(chk_errors),
        .o_jreg_hits(jreg_hits)
    );

    always #10 clk = ~clk;

    function automatic step_t make_step(input logic [2:0] redir, input logic [63:0] rpc,
                                        input int bru, input logic [63:0] jreg,
                                        input bit credit, input bit hold,
                                        input logic [63:0] epc, input logic [2:0] ecnt);
        step_t s;
        s.redir = redir;
        s.rpc = rpc;
        s.bru_pulses = bru;
        s.bru_idx = 4'd8;
        s.jreg = jreg;
        s.credit = credit;
        s.hold = hold;
        s.exp_pc = epc;
        s.exp_count = ecnt;
        return s;
    endfunction

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) & 32'h7fff;
    endfunction

    // the memory keeps only low pc bits, so the line wraps every 1 KB.
    function automatic logic [127:0] line_at(input logic [63:0] pc);
        logic [7:0] base;
        base = {pc[9:4], 2'b00};
        return {prog[base + 3], prog[base + 2], prog[base + 1], prog[base]};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_packet(output bit seen);
        seen = 0;
        for (int c = 0; c < WAIT_LIMIT && !seen; c++) begin
            @(negedge clk);
            if (o_pkt_valid) begin
                seen = 1;
            end else begin
                next_cycle();
            end
        end
        if (seen) begin
            next_cycle();
        end
    endtask

    task automatic run_step(input step_t s);
        bit seen;
        exp_pc = s.exp_pc;
        exp_count = s.exp_count;
        exp_line = line_at(s.exp_pc);
        i_jreg_data = s.jreg;
        for (int b = 0; b < s.bru_pulses; b++) begin
            {i_bru_valid, i_bru_index, i_bru_taken} = {1'b1, s.bru_idx, 1'b1};
            next_cycle();
        end
        i_bru_valid = 1'b0;
        if (s.redir != 3'b000) begin
            i_dec1_pc = s.rpc;
            i_dec2_pc = s.rpc ^ 64'h40;
            i_trap_pc = s.rpc ^ 64'h80;
            {i_dec1_valid, i_dec2_valid, i_trap_valid} = s.redir;
            next_cycle();
            {i_dec1_valid, i_dec2_valid, i_trap_valid} = 3'b000;
        end
        if (s.credit) begin
            repeat (lcg_next() % 4) next_cycle();
            i_credit_return = 1'b1;
            next_cycle();
            i_credit_return = 1'b0;
        end
        wait_packet(seen);
        if (!seen) begin
            $display("step %0d timed out waiting for a packet", step_num);
            tb_errors++;
            timed_out = 1;
        end else if (s.hold) begin
            // decode has spent every credit, so the queue must stay silent.
            for (int c = 0; c < 12; c++) begin
                @(negedge clk);
                if (o_pkt_valid) begin
                    $display("step %0d packet issued with no credits left", step_num);
                    tb_errors++;
                end
                next_cycle();
            end
        end
    endtask

    initial begin
        {clk, i_reset, i_imem_we, i_imem_addr, i_imem_wdata} = '0;
        {i_dec1_valid, i_dec2_valid, i_trap_valid, i_bru_valid, i_bru_taken} = '0;
        {i_dec1_pc, i_dec2_pc, i_trap_pc, i_jreg_data, i_bru_index} = '0;
        {i_credit_return, active, step_num, tb_errors, timed_out} = '0;
        {exp_pc, exp_line, exp_count} = '0;
        lcg_state = 40981;
        // addi x0, x0, word index everywhere, then the control transfers.
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            prog[i] = 32'h0000_0013 | (32'(i) << 20);
        end
        prog[18] = 32'h0400_006f;
        prog[40] = 32'h0200_0063;
        prog[65] = 32'h0082_8067;
        steps[0]  = make_step(3'b000, 0, 0, 0, 0, 0, `FETCH_RESET_PC, 3'd4);
        steps[1]  = make_step(3'b000, 0, 0, 0, 0, 1, 64'h8000_0010, 3'd4);
        steps[2]  = make_step(3'b000, 0, 0, 0, 1, 0, 64'h8000_0020, 3'd4);
        steps[3]  = make_step(3'b000, 0, 0, 0, 1, 1, 64'h8000_0030, 3'd4);
        steps[4]  = make_step(3'b100, 64'h8000_0044, 0, 0, 1, 0, 64'h8000_0044, 3'd2);
        steps[5]  = make_step(3'b000, 0, 0, 0, 1, 0, 64'h8000_0088, 3'd2);
        steps[6]  = make_step(3'b000, 0, 0, 0, 1, 0, 64'h8000_0090, 3'd4);
        steps[7]  = make_step(3'b100, 64'h8000_00a0, 0, 0, 1, 0, 64'h8000_00a0, 3'd4);
        steps[8]  = make_step(3'b000, 0, 0, 0, 1, 0, 64'h8000_00b0, 3'd4);
        steps[9]  = make_step(3'b100, 64'h8000_00a0, 2, 0, 1, 0, 64'h8000_00a0, 3'd1);
        steps[10] = make_step(3'b000, 0, 0, 0, 1, 0, 64'h8000_00c0, 3'd4);
        steps[11] = make_step(3'b100, 64'h8000_0100, 0, 64'h8000_0141, 1, 0,
                              64'h8000_0100, 3'd2);
        steps[12] = make_step(3'b000, 0, 0, 64'h8000_0141, 1, 0, 64'h8000_0148, 3'd2);
        steps[13] = make_step(3'b000, 0, 0, 64'h8000_0141, 1, 0, 64'h8000_0150, 3'd4);
        steps[14] = make_step(3'b111, 64'h8000_0180, 0, 0, 1, 0, 64'h8000_0180, 3'd4);
        steps[15] = make_step(3'b000, 0, 0, 0, 1, 0, 64'h8000_0190, 3'd4);
        steps[16] = make_step(3'b001, 64'h8000_00b4, 0, 0, 1, 0, 64'h8000_0034, 3'd3);
        steps[17] = make_step(3'b000, 0, 0, 0, 1, 0, 64'h8000_0040, 3'd3);
        steps[18] = make_step(3'b010, 64'h8000_00a8, 0, 0, 1, 0, 64'h8000_00e8, 3'd2);

        // reset stays high while the whole program loads.
        i_reset = 1'b1;
        next_cycle();
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            {i_imem_we, i_imem_addr, i_imem_wdata} = {1'b1, 8'(i), prog[i]};
            next_cycle();
        end
        i_imem_we = 1'b0;
        repeat (4) next_cycle();
        i_reset = 1'b0;
        active = 1'b1;

        for (int s = 0; s < NUM_STEPS && !timed_out; s++) begin
            step_num = s;
            run_step(steps[s]);
        end
        repeat (2) next_cycle();

        if (jreg_hits == 0) begin
            $display("o_jreg_en never went high for the jalr");
            tb_errors++;
        end
        if (checks != NUM_STEPS) begin
            $display("checked %0d packets where %0d were expected", checks, NUM_STEPS);
        end
        $display("steps %0d, checks %0d, errors %0d", step_num + 1, checks,
                 chk_errors + tb_errors);
        if (chk_errors + tb_errors == 0 && checks == NUM_STEPS) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+include
design/fetch_pkg.sv
design/branch_history.sv
design/inst_mem.sv
design/fetch_pc.sv
design/fetch_queue.sv
design/fetch_top.sv
verif/fetch_checker.sv
verif/tb_fetch.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fetch
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FLIST     ?= verilog.f
VFLAGS    ?=

SRCS := $(wildcard design/*.sv verif/*.sv include/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) --binary -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR) $(VFLAGS)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
